// File: tb/hawk_decomp_stimulus.txt
// @00 line count, test count; @02 memory lines, 7 words: address, line bits 63:0 .. 383:320
// @40 tests, 10 words: cpage start, free way, size idx, push, initial way,
// page-valid after free, list way, entry id, next id, error injection
@00
6 5
@02
80001000 80001000 8000100000000000 800012000000
0 0 470000
80003000 80003000 8000304000000000 0
0 0 1c30000
80005000 80006000 0 0
0 0 0
80006000 80006000 0 800051000000
80005200 0 d0000
80008000 80008000 8000800000000000 800080400000
80c0000080008080 8000810000008000 bf0000
4000000000000240 33000080008000 7 0
0 0 0
@40
80001200 90000000 1 0 80001000
1 0 0 0 0
80003040 90001000 7 0 80003000
0 0 0 0 0
80005100 90002000 0 0 80006000
4 0 0 0 0
80008080 90003000 2 1 80008000
1b 80008000 9 7 0
8000a000 90004000 0 0 0
0 0 0 0 1

// File: compile.f
+incdir+include
rtl/hawk_axi_pkg.sv
rtl/hawk_zs_pkg.sv
rtl/hawk_rd_fifo.sv
rtl/hawk_decomp_mngr.sv
rtl/hawk_decomp_top.sv
tb/hawk_clk_gen.sv
tb/hawk_decomp_assert.sv
tb/hawk_decomp_tb.sv

// File: Makefile
# Verilator build and run for the decompression subsystem

VERILATOR ?= verilator
TOP       ?= hawk_decomp_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/hawk_decomp_tb.sv
// testbench for the decompression top, plays memory, engine and table manager from a stimulus file
`timescale 1ns/1ps
`default_nettype none
`include "hawk_decomp_config.svh"

module hawk_decomp_tb;

	// five tests, up to 65 beats, about ten cycles a beat worst case
	localparam int CYCLE_LIMIT = 5 * 65 * 10 + 750;

	logic                    clk_i, rst_ni;
	logic                    decomp_trigger;
	logic [`HAWK_ADDR_W-1:0] decomp_cpage_start, decomp_free_way;
	hawk_axi_pkg::rd_rdy_t   rd_rdy;
	hawk_axi_pkg::rd_resp_t  rd_resp;
	logic                    zspg_updated, pgwr_mngr_ready, tbl_update_done, fifo_pop;
	hawk_axi_pkg::rd_req_t   rd_req;
	logic                    rd_arvalid, rd_rready, decomp_start;
	hawk_zs_pkg::way_pkt_t   way_pkt;
	hawk_zs_pkg::tol_upd_t   tol_upd;
	logic [`HAWK_DATA_W-1:0] fifo_data;
	logic                    fifo_empty, mngr_done, bus_error;

	logic [63:0]  stim [0:127];
	logic [63:0]  mem_addr [0:7];
	logic [511:0] mem_data [0:7];
	int           n_lines, n_tests;
	int           req_total, burst_total, err_count, fail_tests, cycles;
	logic         err_inject;
	integer       seed;

	hawk_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) i_clk_gen (.clk_i(clk_i), .rst_ni(rst_ni));

	hawk_decomp_top i_hawk_decomp_top (
		.clk_i, .rst_ni, .decomp_trigger, .decomp_cpage_start, .decomp_free_way,
		.rd_rdy, .rd_resp, .zspg_updated, .pgwr_mngr_ready, .tbl_update_done, .fifo_pop,
		.rd_req, .rd_arvalid, .rd_rready, .decomp_start, .way_pkt, .tol_upd,
		.fifo_data, .fifo_empty, .mngr_done, .bus_error
	);

	task automatic step;
		@(posedge clk_i);
		#2;
	endtask

	task automatic report_error(input string what);
		err_count++;
		$display("Error %0t: %s", $time, what);
	endtask

	function automatic logic [511:0] line_at(input logic [63:0] addr);
		logic [511:0] line;
		line = '0; // unknown lines read as zero
		for (int i = 0; i < n_lines; i++) begin
			if (mem_addr[i] == addr) line = mem_data[i];
		end
		return line;
	endfunction

	// memory model, one read in flight, arready low while it is served
	initial begin : mem_model
		int          wait_cnt;
		logic        pend, pend_burst;
		logic [63:0] pend_addr;
		seed = 32'h24e3d991;
		rd_rdy.arready = 1'b1;
		rd_resp = '0;
		pend = 1'b0;
		pend_burst = 1'b0;
		pend_addr = '0;
		wait_cnt = 0;
		req_total = 0;
		burst_total = 0;
		forever begin
			step();
			rd_resp.rvalid = 1'b0;
			rd_resp.rlast  = 1'b0;
			if (pend) begin
				if (wait_cnt == 0) begin
					rd_resp.rvalid = 1'b1;
					rd_resp.rlast  = 1'b1;
					rd_resp.rresp  = (err_inject && !pend_burst) ? 2'b10 : 2'b00;
					rd_resp.rdata  = pend_burst ? {8{pend_addr}} : line_at(pend_addr);
					pend = 1'b0;
				end else begin
					wait_cnt--;
				end
			end else if (rd_arvalid) begin
				pend       = 1'b1;
				pend_addr  = rd_req.addr;
				pend_burst = !rd_rready; // burst beats go to the FIFO
				wait_cnt   = $random(seed) & 3;
				rd_rdy.arready = 1'b0;
				req_total++;
				if (pend_burst) burst_total++;
				if (rd_req.arlen != 8'd0)
					report_error($sformatf("arlen %0d on a single-beat read", rd_req.arlen));
			end else begin
				rd_rdy.arready = (($random(seed) & 3) != 0); // stalls a quarter of the time
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("run stopped, still busy after %0d cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$finish;
	end

	task automatic run_test(input int t);
		logic [63:0] cpage, fway, iway, lway;
		logic [2:0]  sidx;
		logic [4:0]  pgv;
		logic [15:0] eid, nid;
		logic        push, err;
		int          base, beats, got, reqs_before, burst_before, errs_before;
		base  = 64 + 10 * t;
		cpage = stim[base];
		fway  = stim[base+1];
		sidx  = stim[base+2][2:0];
		push  = stim[base+3][0];
		iway  = stim[base+4];
		pgv   = stim[base+5][4:0];
		lway  = stim[base+6];
		eid   = stim[base+7][15:0];
		nid   = stim[base+8][15:0];
		err   = stim[base+9][0];
		errs_before = err_count;
		err_inject = err;
		decomp_cpage_start = cpage;
		decomp_free_way = fway;
		decomp_trigger = 1'b1;
		step();
		decomp_trigger = 1'b0;
		if (err) begin
			while (!bus_error) step();
			reqs_before = req_total;
			repeat (20) step();
			if (req_total != reqs_before) report_error("requests issued after bus error");
		end else begin
			beats = int'(hawk_zs_pkg::cpage_bytes(sidx)) / 64 + 1;
			burst_before = burst_total;
			got = 0;
			if (beats > `HAWK_FIFO_DEPTH) begin
				// engine idle, the FIFO must fill and hold the burst back
				while (burst_total - burst_before < `HAWK_FIFO_DEPTH) step();
				repeat (20) step();
				if (burst_total - burst_before != `HAWK_FIFO_DEPTH)
					report_error($sformatf("%0d burst reads with FIFO full",
						burst_total - burst_before));
			end
			while (got < beats) begin
				fifo_pop = 1'b0;
				if (!fifo_empty) begin
					if (fifo_data != {8{cpage + 64'(got) * 64'd64}})
						report_error($sformatf("beat %0d data %h", got, fifo_data[63:0]));
					fifo_pop = 1'b1;
					got++;
				end
				step();
			end
			fifo_pop = 1'b0;
			while (!way_pkt.update) step();
			if (burst_total - burst_before != beats)
				report_error($sformatf("%0d burst reads expected %0d",
					burst_total - burst_before, beats));
			if (way_pkt.cpage_size != hawk_zs_pkg::cpage_bytes(sidx))
				report_error($sformatf("cpage_size %0d", way_pkt.cpage_size));
			if (way_pkt.cpage_start != fway[47:0])
				report_error($sformatf("cpage_start %h", way_pkt.cpage_start));
			if (way_pkt.md.pg_vld != pgv)
				report_error($sformatf("pg_vld %b expected %b", way_pkt.md.pg_vld, pgv));
			if (way_pkt.iway_ptr != iway[47:0])
				report_error($sformatf("iway_ptr %h expected %h", way_pkt.iway_ptr, iway[47:0]));
			if (way_pkt.pp_ifl != push) report_error("push-to-free-list flag wrong");
			if (!decomp_start) report_error("decomp_start low during update");
			zspg_updated = 1'b1;
			step();
			zspg_updated = 1'b0;
			if (push) begin
				repeat (16) begin
					if (tol_upd.tbl_update) report_error("tbl_update without pgwr_mngr_ready");
					step();
				end
				pgwr_mngr_ready = 1'b1;
				step();
				while (!tol_upd.tbl_update) step();
				if (tol_upd.dst_list != hawk_zs_pkg::LST_IFL_SIZE1) report_error("dst_list");
				if (tol_upd.src_list != hawk_zs_pkg::LST_DETACH) report_error("src_list");
				if (tol_upd.lst_entry.att_id != 16'd0) report_error("att_id not cleared");
				if (tol_upd.entry_id != eid || tol_upd.lst_entry.entry_id != eid)
					report_error($sformatf("entry_id %0d expected %0d", tol_upd.entry_id, eid));
				if (tol_upd.lst_entry.way != lway[47:0]) report_error("list entry way");
				if (tol_upd.lst_entry.next_id != nid) report_error("list entry next_id");
				if (tol_upd.ifl_idx != sidx) report_error("ifl_idx");
				tbl_update_done = 1'b1;
				step();
				tbl_update_done = 1'b0;
				pgwr_mngr_ready = 1'b0;
			end
			while (!mngr_done) begin
				if (tol_upd.tbl_update) report_error("tbl_update outside the push phase");
				step();
			end
			step(); // back in IDLE with mngr_done low
		end
		if (err_count != errs_before) fail_tests++;
		$display("test %0d: %s", t, (err_count == errs_before) ? "ok" : "FAILED");
	endtask

	initial begin : main
		int b;
		decomp_trigger = 1'b0;
		decomp_cpage_start = '0;
		decomp_free_way = '0;
		zspg_updated = 1'b0;
		pgwr_mngr_ready = 1'b0;
		tbl_update_done = 1'b0;
		fifo_pop = 1'b0;
		err_inject = 1'b0;
		err_count = 0;
		fail_tests = 0;
		$readmemh("tb/hawk_decomp_stimulus.txt", stim);
		n_lines = int'(stim[0][3:0]);
		n_tests = int'(stim[1][3:0]);
		if (n_lines > 8) n_lines = 8;
		for (int i = 0; i < n_lines; i++) begin
			b = 2 + 7 * i;
			mem_addr[i] = stim[b];
			mem_data[i] = {128'd0, stim[b+6], stim[b+5], stim[b+4], stim[b+3], stim[b+2], stim[b+1]};
		end
		while (rst_ni !== 1'b1) step();
		step();
		for (int t = 0; t < n_tests; t++) run_test(t);
		$display("%0d tests run, %0d failed, %0d errors", n_tests, fail_tests, err_count);
		if (fail_tests == 0 && err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/hawk_decomp_assert.sv
// protocol assertions for the decompression manager, attached to every instance by bind
`timescale 1ns/1ps
`default_nettype none

module hawk_decomp_assert (
	input wire logic clk_i,
	input wire logic rst_ni,
	input wire logic rd_arvalid,
	input wire logic arready,
	input wire logic rdm_reset,
	input wire logic mngr_done,
	input wire logic bus_error
);

	// request only goes out when the bus was ready the cycle it was decided
	a_arvalid_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(rd_arvalid) |-> $past(arready))
		else $error("rd_arvalid rose while arready was low");

	a_rdm_reset_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rdm_reset |=> !rdm_reset)
		else $error("rdm_reset held longer than one cycle");

	a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mngr_done |=> !mngr_done)
		else $error("mngr_done held longer than one cycle");

	// sticky until reset
	a_bus_error_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error |=> bus_error)
		else $error("bus_error dropped without reset");

endmodule

bind hawk_decomp_mngr hawk_decomp_assert i_assert (
	.clk_i     (clk_i),
	.rst_ni    (rst_ni),
	.rd_arvalid(rd_arvalid),
	.arready   (rd_rdy.arready),
	.rdm_reset (rdm_reset),
	.mngr_done (mngr_done),
	.bus_error (bus_error)
);

`default_nettype wire

// File: tb/hawk_clk_gen.sv
// clock and reset source for the decompression testbench, instantiate once at the top
`timescale 1ns/1ps
`default_nettype none

module hawk_clk_gen #(
	parameter int unsigned PERIOD_NS  = 20,
	parameter int unsigned RST_CYCLES = 4
) (
	output logic clk_i,
	output logic rst_ni
);

	initial begin
		clk_i = 1'b0;
		forever #(PERIOD_NS / 2) clk_i = ~clk_i;
	end

	initial begin
		rst_ni = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_i);
		#2 rst_ni = 1'b1; // released off the edge like the other inputs
	end

endmodule

`default_nettype wire

// File: rtl/hawk_decomp_top.sv
// decompression subsystem top, manager plus read-data FIFO, everything else sits outside
`timescale 1ns/1ps
`default_nettype none
`include "hawk_decomp_config.svh"

module hawk_decomp_top (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    decomp_trigger,
	input  logic [`HAWK_ADDR_W-1:0] decomp_cpage_start,
	input  logic [`HAWK_ADDR_W-1:0] decomp_free_way,
	input  hawk_axi_pkg::rd_rdy_t   rd_rdy,
	input  hawk_axi_pkg::rd_resp_t  rd_resp,
	input  logic                    zspg_updated,
	input  logic                    pgwr_mngr_ready,
	input  logic                    tbl_update_done,
	input  logic                    fifo_pop,
	output hawk_axi_pkg::rd_req_t   rd_req,
	output logic                    rd_arvalid,
	output logic                    rd_rready,
	output logic                    decomp_start,
	output hawk_zs_pkg::way_pkt_t   way_pkt,
	output hawk_zs_pkg::tol_upd_t   tol_upd,
	output logic [`HAWK_DATA_W-1:0] fifo_data,
	output logic                    fifo_empty,
	output logic                    mngr_done,
	output logic                    bus_error
);

	logic rdm_reset; // one-cycle FIFO clear
	logic fifo_full;

	hawk_decomp_mngr i_mngr (
		.clk_i           (clk_i),
		.rst_ni          (rst_ni),
		.decomp_trigger  (decomp_trigger),
		.decomp_cpage_start(decomp_cpage_start),
		.decomp_free_way (decomp_free_way),
		.rd_rdy          (rd_rdy),
		.rd_resp         (rd_resp),
		.rdfifo_full     (fifo_full),
		.rdfifo_empty    (fifo_empty),
		.zspg_updated    (zspg_updated),
		.pgwr_mngr_ready (pgwr_mngr_ready),
		.tbl_update_done (tbl_update_done),
		.rd_req          (rd_req),
		.rd_arvalid      (rd_arvalid),
		.rd_rready       (rd_rready),
		.rdm_reset       (rdm_reset),
		.decomp_start    (decomp_start),
		.way_pkt         (way_pkt),
		.tol_upd         (tol_upd),
		.mngr_done       (mngr_done),
		.bus_error       (bus_error)
	);

	hawk_rd_fifo #(
		.DEPTH(`HAWK_FIFO_DEPTH)
	) i_fifo (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.clr    (rdm_reset),
		.rd_resp(rd_resp),
		.rready (rd_rready), // low rready steers beats here
		.pop    (fifo_pop),
		.data   (fifo_data),
		.full   (fifo_full),
		.empty  (fifo_empty)
	);

endmodule

`default_nettype wire

// File: rtl/hawk_decomp_mngr.sv
// decompression manager FSM, walks the way chain, frees the page, reads it out and updates the free list
`timescale 1ns/1ps
`default_nettype none
`include "hawk_decomp_config.svh"

module hawk_decomp_mngr (
	input  logic                       clk_i,
	input  logic                       rst_ni,
	input  logic                       decomp_trigger,
	input  logic [`HAWK_ADDR_W-1:0]    decomp_cpage_start,
	input  logic [`HAWK_ADDR_W-1:0]    decomp_free_way,
	input  hawk_axi_pkg::rd_rdy_t      rd_rdy,
	input  hawk_axi_pkg::rd_resp_t     rd_resp,
	input  logic                       rdfifo_full,
	input  logic                       rdfifo_empty,
	input  logic                       zspg_updated,
	input  logic                       pgwr_mngr_ready,
	input  logic                       tbl_update_done,
	output hawk_axi_pkg::rd_req_t      rd_req,
	output logic                       rd_arvalid,
	output logic                       rd_rready,
	output logic                       rdm_reset,
	output logic                       decomp_start,
	output hawk_zs_pkg::way_pkt_t      way_pkt,
	output hawk_zs_pkg::tol_upd_t      tol_upd,
	output logic                       mngr_done,
	output logic                       bus_error
);

	localparam logic [`HAWK_ADDR_W-1:0] PPA_START = `HAWK_PPA_START;
	localparam int unsigned MD_W = $bits(hawk_zs_pkg::zspg_md_t);

	hawk_zs_pkg::mngr_state_e state_q, n_state;
	hawk_axi_pkg::rd_req_t    req_q, n_req;
	hawk_zs_pkg::way_pkt_t    way_q, n_way;
	hawk_zs_pkg::lst_entry_t  lst_q, n_lst;
	logic [`HAWK_DATA_W-1:0]  rdata_q, n_rdata;
	logic [6:0]               burst_cnt_q, n_burst_cnt;
	logic                     n_arvalid, n_decomp_start, n_done, n_rdm_reset;
	logic                     arready;
	logic [47:0]              way_off;
	logic [15:0]              lst_entry_id;

	// single-beat read into a target region
	function automatic hawk_axi_pkg::rd_req_t mk_req(
		input hawk_axi_pkg::rd_target_e tgt,
		input logic [`HAWK_ADDR_W-1:0]  addr
	);
		hawk_axi_pkg::rd_req_t r;
		r.addr  = {tgt, addr[`HAWK_ADDR_W-3:0]};
		r.arlen = 8'd0;
		return r;
	endfunction

	// first pass records fullness, second pass frees the matching page
	function automatic hawk_zs_pkg::way_pkt_t md_decode(
		input logic [`HAWK_DATA_W-1:0] line,
		input logic [47:0]             cpage_start,
		input logic                    first,
		input hawk_zs_pkg::way_pkt_t   pkt_in
	);
		hawk_zs_pkg::way_pkt_t pkt;
		logic hit;
		pkt = pkt_in;
		hit = 1'b0;
		pkt.iway_ptr    = line[47:0];
		pkt.nxtway_ptr  = line[95:48];
		pkt.md          = line[96 +: MD_W];
		pkt.cpage_size  = hawk_zs_pkg::cpage_bytes(pkt.md.size);
		pkt.cpage_start = cpage_start;
		pkt.update      = 1'b0;
		if (first) begin
			pkt.pp_ifl = &pkt.md.pg_vld;
		end else begin
			for (int i = 0; i < `HAWK_PG_PER_ZSPG; i++) begin
				if (!hit && pkt.md.page[i] == cpage_start) begin
					pkt.md.pg_vld[i] = 1'b0;
					hit = 1'b1;
				end
			end
		end
		return pkt;
	endfunction

	function automatic hawk_zs_pkg::lst_entry_t lst_decode(
		input logic [`HAWK_DATA_W-1:0] line,
		input logic [15:0]             id
	);
		hawk_zs_pkg::lst_entry_t e;
		e.way      = line[47:0];
		e.entry_id = id;
		e.att_id   = line[63:48];
		e.next_id  = line[79:64];
		return e;
	endfunction

	function automatic logic [2:0] size_to_idx(input logic [13:0] bytes);
		logic [2:0] idx;
		idx = 3'd0;
		for (int i = 0; i < 8; i++) begin
			if (hawk_zs_pkg::cpage_bytes(3'(i)) == bytes) begin
				idx = 3'(i);
			end
		end
		return idx;
	endfunction

	assign arready      = rd_rdy.arready;
	assign way_off      = way_q.iway_ptr - PPA_START[47:0];
	assign lst_entry_id = way_off[27:12] + 16'd1; // entry 0 is reserved

	always_comb begin
		n_state        = state_q;
		n_req          = req_q;
		n_arvalid      = 1'b0;
		n_rdata        = rdata_q;
		n_way          = way_q;
		n_lst          = lst_q;
		n_burst_cnt    = burst_cnt_q;
		n_decomp_start = decomp_start; // held until reset
		n_done         = 1'b0;
		n_rdm_reset    = 1'b0;
		rd_rready      = 1'b1;
		tol_upd        = '0;
		case (state_q)
			hawk_zs_pkg::IDLE: begin
				if (decomp_trigger && !mngr_done) begin
					n_req   = mk_req(hawk_axi_pkg::RD_TGT_DRAM, {decomp_cpage_start[`HAWK_ADDR_W-1:12], 12'd0});
					n_state = hawk_zs_pkg::REQ_IWAY_PTR;
				end
			end
			hawk_zs_pkg::REQ_IWAY_PTR: begin
				if (arready && !rd_arvalid) begin
					n_arvalid = 1'b1;
					n_state   = hawk_zs_pkg::FETCH_IWAY_PTR;
				end
			end
			hawk_zs_pkg::FETCH_IWAY_PTR: begin
				if (rd_resp.rvalid && rd_resp.rlast) begin
					if (rd_resp.rresp != 2'd0) begin
						n_state = hawk_zs_pkg::BUS_ERROR;
					end else if (rd_resp.rdata[47:0] == req_q.addr[47:0]) begin
						n_rdata     = rd_resp.rdata;
						n_way       = md_decode(rd_resp.rdata, decomp_cpage_start[47:0], 1'b1, way_q);
						n_burst_cnt = n_way.cpage_size[12:6] + 7'd1;
						n_state     = hawk_zs_pkg::SET_CPAGEFREE;
					end else begin
						// not the initial way yet, hop along the chain
						n_req   = mk_req(hawk_axi_pkg::RD_TGT_DRAM,
							{{(`HAWK_ADDR_W-48){1'b0}}, rd_resp.rdata[47:0]});
						n_state = hawk_zs_pkg::REQ_IWAY_PTR;
					end
				end
			end
			hawk_zs_pkg::SET_CPAGEFREE: begin
				n_way   = md_decode(rdata_q, decomp_cpage_start[47:0], 1'b0, way_q);
				n_state = hawk_zs_pkg::RESET_FIFO;
			end
			hawk_zs_pkg::RESET_FIFO: begin
				n_rdm_reset = 1'b1;
				n_state     = hawk_zs_pkg::WAIT_RESET;
			end
			hawk_zs_pkg::WAIT_RESET: n_state = hawk_zs_pkg::BURST_START;
			hawk_zs_pkg::BURST_START: begin
				rd_rready = 1'b0; // beats go to the FIFO
				if (arready && !rd_arvalid && burst_cnt_q != 7'd0 && rdfifo_empty) begin
					n_req       = mk_req(hawk_axi_pkg::RD_TGT_DRAM, decomp_cpage_start);
					n_arvalid   = 1'b1;
					n_burst_cnt = burst_cnt_q - 7'd1;
					n_state     = hawk_zs_pkg::BURST_READ;
				end
			end
			hawk_zs_pkg::BURST_READ: begin
				rd_rready = 1'b0;
				if (arready && !rd_arvalid && burst_cnt_q != 7'd0 && !rdfifo_full) begin
					n_req       = mk_req(hawk_axi_pkg::RD_TGT_DRAM, req_q.addr + `HAWK_ADDR_W'(64));
					n_arvalid   = 1'b1;
					n_burst_cnt = burst_cnt_q - 7'd1;
				end else if (burst_cnt_q == 7'd0) begin
					n_decomp_start    = 1'b1;
					n_way.cpage_start = decomp_free_way[47:0];
					n_way.update      = 1'b1;
					n_state           = hawk_zs_pkg::DECOMP_WAIT;
				end
			end
			hawk_zs_pkg::DECOMP_WAIT: begin
				rd_rready = 1'b0; // trailing beats still land in the FIFO
				if (zspg_updated) begin
					n_way.update = 1'b0;
					n_state      = way_q.pp_ifl ? hawk_zs_pkg::FETCH_LST_ENTRY : hawk_zs_pkg::DONE;
				end
			end
			hawk_zs_pkg::FETCH_LST_ENTRY: begin
				if (arready && !rd_arvalid) begin
					n_req     = mk_req(hawk_axi_pkg::RD_TGT_TOL,
						{{(`HAWK_ADDR_W-22){1'b0}}, lst_entry_id, 6'd0});
					n_arvalid = 1'b1;
					n_state   = hawk_zs_pkg::WAIT_LST_ENTRY;
				end
			end
			hawk_zs_pkg::WAIT_LST_ENTRY: begin
				if (rd_resp.rvalid && rd_resp.rlast) begin
					if (rd_resp.rresp != 2'd0) begin
						n_state = hawk_zs_pkg::BUS_ERROR;
					end else begin
						n_rdata = rd_resp.rdata;
						n_state = hawk_zs_pkg::DECODE_LST_ENTRY;
					end
				end
			end
			hawk_zs_pkg::DECODE_LST_ENTRY: begin
				n_lst   = lst_decode(rdata_q, lst_entry_id);
				n_state = hawk_zs_pkg::PUSH_IFL;
			end
			hawk_zs_pkg::PUSH_IFL: begin
				if (pgwr_mngr_ready) begin
					tol_upd.tbl_update       = 1'b1;
					tol_upd.upd_only         = 1'b1;
					tol_upd.entry_id         = lst_entry_id;
					tol_upd.lst_entry        = lst_q;
					tol_upd.lst_entry.att_id = 16'd0; // no longer mapped
					tol_upd.src_list         = hawk_zs_pkg::LST_DETACH;
					tol_upd.dst_list         = hawk_zs_pkg::LST_IFL_SIZE1;
					tol_upd.ifl_idx          = size_to_idx(way_q.cpage_size);
				end
				if (tbl_update_done) begin
					n_state = hawk_zs_pkg::DONE;
				end
			end
			hawk_zs_pkg::DONE: begin
				n_done  = 1'b1;
				n_state = hawk_zs_pkg::IDLE;
			end
			hawk_zs_pkg::BUS_ERROR: n_state = hawk_zs_pkg::BUS_ERROR; // sticky until reset
			default: n_state = hawk_zs_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q      <= hawk_zs_pkg::IDLE;
			rd_arvalid   <= 1'b0;
			burst_cnt_q  <= 7'd0;
			decomp_start <= 1'b0;
			way_q        <= '0;
			mngr_done    <= 1'b0;
			rdm_reset    <= 1'b0;
		end else begin
			state_q      <= n_state;
			rd_arvalid   <= n_arvalid;
			burst_cnt_q  <= n_burst_cnt;
			decomp_start <= n_decomp_start;
			way_q        <= n_way;
			mngr_done    <= n_done;
			rdm_reset    <= n_rdm_reset;
		end
	end

	// payload, only read under valid control
	always_ff @(posedge clk_i) begin
		req_q   <= n_req;
		rdata_q <= n_rdata;
		lst_q   <= n_lst;
	end

	assign rd_req    = req_q;
	assign way_pkt   = way_q;
	assign bus_error = (state_q == hawk_zs_pkg::BUS_ERROR);

endmodule

`default_nettype wire

// File: rtl/hawk_rd_fifo.sv
// read-data FIFO that catches burst beats for the decompression engine, cleared by the manager
`timescale 1ns/1ps
`default_nettype none
`include "hawk_decomp_config.svh"

module hawk_rd_fifo #(
	parameter int unsigned DEPTH = `HAWK_FIFO_DEPTH
) (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    clr,
	input  hawk_axi_pkg::rd_resp_t  rd_resp,
	input  logic                    rready,
	input  logic                    pop,
	output logic [`HAWK_DATA_W-1:0] data,
	output logic                    full,
	output logic                    empty
);

	localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [`HAWK_DATA_W-1:0] mem [DEPTH];
	logic [AW-1:0]           wr_ptr_q, rd_ptr_q;
	logic [AW:0]             cnt_q;
	logic                    push, do_pop;

	// wrap explicitly so any depth works
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push   = rd_resp.rvalid && !rready && !full; // beat dropped when full
	assign do_pop = pop && !empty;
	assign full   = (cnt_q == (AW+1)'(DEPTH));
	assign empty  = (cnt_q == '0);
	assign data   = mem[rd_ptr_q]; // head beat, show-ahead

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else if (clr) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			cnt_q    <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			if (do_pop) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			if (push && !do_pop) begin
				cnt_q <= cnt_q + 1'b1;
			end else if (do_pop && !push) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (push && !clr) begin
			mem[wr_ptr_q] <= rd_resp.rdata;
		end
	end

endmodule

`default_nettype wire

// File: rtl/hawk_zs_pkg.sv
// zspage metadata, way packet, free-list and manager state types for the decompression path
`default_nettype none
`include "hawk_decomp_config.svh"

package hawk_zs_pkg;

	// metadata as laid out above the two way pointers of a zspage line
	typedef struct packed {
		logic [2:0]                          size; // index into cpage_bytes
		logic [`HAWK_PG_PER_ZSPG-1:0]        pg_vld;
		logic                                way_vld;
		logic [`HAWK_PG_PER_ZSPG-1:0][47:0] page; // compressed page byte starts
	} zspg_md_t;

	typedef struct packed {
		zspg_md_t    md;
		logic [47:0] iway_ptr;
		logic [47:0] nxtway_ptr;
		logic [13:0] cpage_size; // bytes
		logic [47:0] cpage_start;
		logic        update; // valid for the engine
		logic        pp_ifl; // zspage was full, push to free list
	} way_pkt_t;

	typedef struct packed {
		logic [47:0] way;
		logic [15:0] entry_id;
		logic [15:0] att_id;
		logic [15:0] next_id;
	} lst_entry_t;

	typedef enum logic [1:0] {
		LST_DETACH    = 2'd0,
		LST_IFL_SIZE1 = 2'd1
	} list_e;

	typedef struct packed {
		logic       tbl_update;
		logic       upd_only;
		logic [15:0] entry_id;
		lst_entry_t lst_entry;
		list_e      src_list;
		list_e      dst_list;
		logic [2:0] ifl_idx;
	} tol_upd_t;

	typedef enum logic [3:0] {
		IDLE, REQ_IWAY_PTR, FETCH_IWAY_PTR, SET_CPAGEFREE, RESET_FIFO, WAIT_RESET,
		BURST_START, BURST_READ, DECOMP_WAIT, FETCH_LST_ENTRY, WAIT_LST_ENTRY,
		DECODE_LST_ENTRY, PUSH_IFL, DONE, BUS_ERROR
	} mngr_state_e;

	// supported compressed page sizes
	function automatic logic [13:0] cpage_bytes(input logic [2:0] idx);
		case (idx)
			3'd0: return 14'd64;
			3'd1: return 14'd128;
			3'd2: return 14'd256;
			3'd3: return 14'd512;
			3'd4: return 14'd1024;
			3'd5: return 14'd2048;
			3'd6: return 14'd3072;
			default: return 14'd4096;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: rtl/hawk_axi_pkg.sv
// read-bus packet types shared by the decompression manager, the FIFO and the testbench
`default_nettype none
`include "hawk_decomp_config.svh"

package hawk_axi_pkg;

	// address channel payload, arlen is beats minus one
	typedef struct packed {
		logic [`HAWK_ADDR_W-1:0] addr;
		logic [7:0]              arlen;
	} rd_req_t;

	typedef struct packed {
		logic arready;
	} rd_rdy_t;

	// read data channel
	typedef struct packed {
		logic                    rvalid;
		logic                    rlast;
		logic [1:0]              rresp; // nonzero is an error
		logic [`HAWK_DATA_W-1:0] rdata;
	} rd_resp_t;

	// region a read goes to, placed in the top address bits
	typedef enum logic [1:0] {
		RD_TGT_DRAM = 2'd0,
		RD_TGT_TOL  = 2'd1
	} rd_target_e;

endpackage

`default_nettype wire

// File: include/hawk_decomp_config.svh
// build-wide sizes for the decompression path, included by packages and RTL that need them
`ifndef HAWK_DECOMP_CONFIG_SVH
`define HAWK_DECOMP_CONFIG_SVH

// read bus
`define HAWK_ADDR_W 64
`define HAWK_DATA_W 512 // one cacheline per beat

// read-data FIFO, one 4 KB page of beats
`define HAWK_FIFO_DEPTH 64

// zspage geometry
`define HAWK_PG_PER_ZSPG 5

// first way of the physical page region, list entry ids count from here
`define HAWK_PPA_START 64'h0000_0000_8000_0000

`endif
